// ==== tb.f ====
source/exec_pkg.sv
source/alu.sv
source/alu_decode.sv
source/reg_file.sv
source/branch_unit.sv
source/exec_core.sv
verif/exec_checker.sv
verif/exec_core_tb.sv

// ==== Bender.yml ====
package:
  name: exec_core

sources:
  - source/exec_pkg.sv
  - source/alu.sv
  - source/alu_decode.sv
  - source/reg_file.sv
  - source/branch_unit.sv
  - source/exec_core.sv
  - target: test
    files:
      - verif/exec_checker.sv
      - verif/exec_core_tb.sv

// ==== verif/exec_core_tb.sv ====
`timescale 1ns/1ns

module exec_core_tb;

  import exec_pkg::*;

  logic            clk;
  logic            rst;
  logic            issue;
  logic [xlen-1:0] instr;
  logic [xlen-1:0] pc;
  logic            done;
  exec_out_t       out;
  int              errors;
  int              checks;
  int              pending;
  logic [xlen-1:0] cur_pc;
  int unsigned     seed;
  int              imm_list [5] = '{0, -1, 2047, -2048, 5};

  exec_core exec_core_i (
    .clk   (clk),
    .rst   (rst),
    .issue (issue),
    .instr (instr),
    .pc    (pc),
    .done  (done),
    .out   (out)
  );

  exec_checker exec_checker_i (
    .clk     (clk),
    .rst     (rst),
    .issue   (issue),
    .instr   (instr),
    .pc      (pc),
    .done    (done),
    .out     (out),
    .errors  (errors),
    .checks  (checks),
    .pending (pending)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [xlen-1:0] r_format(input int f7, input int rs2, input int rs1,
                                               input int f3, input int rd);
    return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), op_reg};
  endfunction

  function automatic logic [xlen-1:0] i_format(input int imm, input int rs1, input int f3,
                                               input int rd);
    return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), op_imm};
  endfunction

  function automatic logic [xlen-1:0] b_format(input int off, input int rs2, input int rs1,
                                               input int f3);
    logic [12:0] o;
    o = 13'(off);
    return {o[12], o[10:5], 5'(rs2), 5'(rs1), 3'(f3), o[4:1], o[11], op_branch};
  endfunction

  function automatic logic [xlen-1:0] random_legal();
    int f3;
    int f7;
    int imm;
    int rs1;
    int rs2;
    int rd;
    f3  = $urandom % 8;
    rs1 = $urandom % 32;
    rs2 = $urandom % 32;
    rd  = $urandom % 32;
    case ($urandom % 3)
      0:
      begin
        f7 = ($urandom % 2) ? 7'h01 : 7'h00;
        if ((f3 == 0 || f3 == 5) && $urandom % 3 == 0)
          f7 = 7'h20;
        return r_format(f7, rs2, rs1, f3, rd);
      end
      1:
      begin
        imm = $urandom;
        if (f3 == 1 || f3 == 5)
          imm = (f3 == 5 && $urandom % 2) ? 32'h400 | rs2 : rs2;  // Legal shift encodings
        return i_format(imm, rs1, f3, rd);
      end
      default: return b_format($urandom, rs2, rs1, (f3 == 2 || f3 == 3) ? f3 + 2 : f3);
    endcase
  endfunction

  task automatic send(input logic [xlen-1:0] word);
    @(posedge clk);
    #1;
    issue  = 1'b1;
    instr  = word;
    pc     = cur_pc;
    cur_pc = cur_pc + 32'd4;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles)
    begin
      @(posedge clk);
      #1;
      issue = 1'b0;
      instr = $urandom;  // Junk word that must not write back
      pc    = $urandom;
    end
  endtask

  initial
  begin
    issue  = 1'b0;
    instr  = '0;
    pc     = '0;
    rst    = 1'b1;
    cur_pc = 32'h1000;
    seed   = 32'hd48c;
    void'($urandom(seed));
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;

    for (int r = 0; r < 32; r++)
      send(r_format(0, r, r, 6, 0));  // OR into x0 reads every register
    idle(2);

    // Corner operands in x1 to x7
    send(i_format(0, 0, 0, 1));
    send(i_format(-1, 0, 0, 2));
    send(i_format(1, 0, 0, 3));
    send(i_format(31, 3, 1, 3));      // Most negative number
    send(i_format(63, 0, 0, 4));
    send(i_format(7, 0, 0, 5));
    send(i_format(-2048, 0, 0, 6));
    send(i_format(2047, 0, 0, 7));
    idle(1);

    for (int f3 = 0; f3 < 8; f3++)
      for (int r1 = 1; r1 <= 7; r1++)
        for (int r2 = 1; r2 <= 7; r2++)
        begin
          send(r_format(7'h00, r2, r1, f3, 20));
          send(r_format(7'h01, r2, r1, f3, 21));
          if (f3 == 0 || f3 == 5)
            send(r_format(7'h20, r2, r1, f3, 22));
          if (f3 != 2 && f3 != 3)
            send(b_format((r1 + r2) % 2 ? 16 : -8, r2, r1, f3));
        end

    for (int r1 = 1; r1 <= 7; r1++)
    begin
      for (int f3 = 0; f3 < 8; f3++)
        if (f3 != 1 && f3 != 5)
          foreach (imm_list[k])
            send(i_format(imm_list[k], r1, f3, 23));
      foreach (imm_list[k])
      begin
        send(i_format(imm_list[k] & 31, r1, 1, 24));
        send(i_format(imm_list[k] & 31, r1, 5, 24));
        send(i_format(12'h400 | (imm_list[k] & 31), r1, 5, 24));
      end
    end
    idle(2);

    // Dependent chain and x0 write
    send(i_format(5, 0, 0, 10));
    send(r_format(0, 10, 10, 0, 11));
    send(r_format(7'h20, 10, 11, 0, 12));
    send(r_format(1, 11, 12, 0, 13));
    send(i_format(77, 0, 0, 0));
    send(r_format(0, 0, 0, 0, 14));

    send(32'h0000_2083);              // Load word
    send(r_format(7'h10, 2, 2, 0, 1));
    send(i_format(12'h403, 2, 1, 1));
    send(i_format(12'h023, 2, 5, 1));
    send(b_format(8, 2, 2, 2));
    send(r_format(0, 0, 1, 0, 15));   // x1 still zero
    idle(2);

    for (int n = 0; n < 400; n++)
    begin
      cur_pc = $urandom & 32'hffff_fffc;
      send(random_legal());
      idle($urandom % 4);
    end
    idle(1);

    for (int t = 0; t < 10 && pending != 0; t++)
      @(negedge clk);
    if (pending != 0)
      $display("%0d instructions never completed", pending);
    $display("Checks %0d, errors %0d, outstanding %0d", checks, errors, pending);
    if (errors == 0 && pending == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

// ==== verif/exec_checker.sv ====
`timescale 1ns/1ns

module exec_checker (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      issue,
  input  logic [exec_pkg::xlen-1:0] instr,
  input  logic [exec_pkg::xlen-1:0] pc,
  input  logic                      done,
  input  exec_pkg::exec_out_t       out,
  output int                        errors,
  output int                        checks,
  output int                        pending
);

  import exec_pkg::*;

  logic [xlen-1:0] model [nregs];  // Expected register contents
  exec_out_t       exp_q [$];
  int              issue_cycle [$];
  int              cycle;
  exec_out_t       exp_out;

  // RV32I integer ops where alt picks SUB and SRA
  function automatic logic [xlen-1:0] base_op(input logic [2:0] f3, input logic alt,
                                              input logic [xlen-1:0] a, input logic [xlen-1:0] b);
    logic signed [xlen-1:0] sa;
    logic signed [xlen-1:0] sb;
    sa = a;
    sb = b;
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, sa < sb};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5:
      begin
        if (alt)
          return sa >>> b[4:0];
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic [xlen-1:0] muldiv(input logic [2:0] f3, input logic [xlen-1:0] a,
                                             input logic [xlen-1:0] b);
    longint          sa;
    longint          sb;
    longint unsigned ua;
    longint unsigned ub;
    sa = $signed(a);
    sb = $signed(b);
    ua = a;
    ub = b;
    if (f3[2] && b == '0)
      return f3[1] ? a : '1;                // Divide by zero
    case (f3)
      3'd0: return 32'(sa * sb);
      3'd1: return 32'((sa * sb) >>> 32);
      3'd2: return 32'((sa * longint'(ub)) >>> 32);
      3'd3: return 32'((ua * ub) >> 32);
      3'd4: return 32'(sa / sb);            // Overflow wraps back to dividend
      3'd5: return 32'(ua / ub);
      3'd6: return 32'(sa % sb);
      default: return 32'(ua % ub);
    endcase
  endfunction

  function automatic exec_out_t predict_out(input logic [xlen-1:0] word,
                                            input logic [xlen-1:0] at_pc,
                                            input logic [xlen-1:0] a, input logic [xlen-1:0] b);
    exec_out_t       e;
    logic [6:0]      f7;
    logic [2:0]      f3;
    logic [xlen-1:0] imm;
    logic            ok;
    logic            lt;
    e       = '0;
    imm     = '0;
    f7      = word[31:25];
    f3      = word[14:12];
    ok      = 1'b1;
    e.rd    = word[11:7];
    e.wr_en = 1'b1;
    case (word[6:0])
      op_reg:
      begin
        if (f7 == 7'h01)
          e.result = muldiv(f3, a, b);
        else if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)))
          e.result = base_op(f3, f7[5], a, b);
        else
          ok = 1'b0;
      end
      op_imm:
      begin
        imm      = {{20{word[31]}}, word[31:20]};
        // Shift immediates keep funct7 in the upper bits
        ok       = (f3 == 3'd1) ? (f7 == 7'h00) : (f3 != 3'd5 || f7 == 7'h00 || f7 == 7'h20);
        e.result = base_op(f3, f3 == 3'd5 && f7[5], a, imm);
      end
      op_branch:
      begin
        imm     = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
        ok      = (f3 != 3'd2 && f3 != 3'd3);
        e.wr_en = 1'b0;
        if (!f3[2])
        begin
          e.result       = a - b;
          e.branch_taken = (a == b) ^ f3[0];  // BEQ or BNE
        end
        else
        begin
          lt             = f3[1] ? (a < b) : ($signed(a) < $signed(b));
          e.result       = {31'b0, lt};
          e.branch_taken = lt ^ f3[0];
        end
      end
      default: ok = 1'b0;
    endcase
    if (!ok)
    begin
      e.illegal      = 1'b1;
      e.wr_en        = 1'b0;
      e.branch_taken = 1'b0;
    end
    e.next_pc = e.branch_taken ? at_pc + imm : at_pc + 32'd4;
    return e;
  endfunction

  task automatic check_field(input string name, input logic [$bits(exec_out_t)-1:0] exp_v,
                             input logic [$bits(exec_out_t)-1:0] got);
    checks++;
    if (got !== exp_v)
    begin
      errors++;
      $display("FAILED %0t %s expected %0h got %0h", $time, name, exp_v, got);
    end
  endtask

  task automatic compare_out(input exec_out_t e);
    if (!e.illegal)
      check_field("out.result", e.result, out.result);  // No result defined when illegal
    check_field("out.rd", e.rd, out.rd);
    check_field("out.wr_en", e.wr_en, out.wr_en);
    check_field("out.branch_taken", e.branch_taken, out.branch_taken);
    check_field("out.next_pc", e.next_pc, out.next_pc);
    check_field("out.illegal", e.illegal, out.illegal);
  endtask

  initial
  begin
    errors  = 0;
    checks  = 0;
    pending = 0;
    cycle   = 0;
  end

  always @(negedge clk)
  begin
    if (rst)
    begin
      foreach (model[i])
        model[i] = '0;
      exp_q.delete();
      issue_cycle.delete();
      check_field("done", 1'b0, done);
      check_field("out", '0, out);
    end
    else
    begin
      if (done === 1'b1)
      begin
        if (exp_q.size() == 0)
        begin
          errors++;
          $display("done pulsed at %0t with no instruction outstanding", $time);
        end
        else
        begin
          exp_out = exp_q.pop_front();
          if (cycle - issue_cycle.pop_front() != 1)
          begin
            errors++;
            $display("done at %0t did not come one cycle after its issue", $time);
          end
          compare_out(exp_out);
        end
      end
      else if (issue_cycle.size() != 0 && cycle - issue_cycle[0] >= 4)
      begin
        errors++;
        $display("No done within 4 cycles of the issue in cycle %0d", issue_cycle[0]);
        exp_q.delete(0);
        issue_cycle.delete(0);
      end
      if (issue === 1'b1)
      begin
        exp_out = predict_out(instr, pc, model[instr[19:15]], model[instr[24:20]]);
        exp_q.push_back(exp_out);
        issue_cycle.push_back(cycle);
        if (exp_out.wr_en && exp_out.rd != '0)
          model[exp_out.rd] = exp_out.result;   // Visible to the next issue
      end
    end
    cycle++;
    pending = exp_q.size();
  end

endmodule

// ==== source/exec_core.sv ====
`timescale 1ns/1ns

module exec_core (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      issue,
  input  logic [exec_pkg::xlen-1:0] instr,
  input  logic [exec_pkg::xlen-1:0] pc,
  output logic                      done,
  output exec_pkg::exec_out_t       out
);

  import exec_pkg::*;

  dec_t            dec;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] alu_result;
  logic            alu_zero;
  logic            taken;
  logic [xlen-1:0] next_pc;
  exec_out_t       out_d;

  alu_decode alu_decode_i (
    .instr (instr),
    .dec   (dec)
  );

  reg_file reg_file_i (
    .clk      (clk),
    .rst      (rst),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr       (issue && dec.wr_en),  // Write lands at end of issue cycle
    .rd       (dec.rd),
    .wr_data  (alu_result)
  );

  assign op_b = dec.use_imm ? dec.imm : rs2_data;

  alu alu_i (
    .op     (dec.op),
    .a      (rs1_data),
    .b      (op_b),
    .result (alu_result),
    .zero   (alu_zero)
  );

  branch_unit branch_unit_i (
    .cls     (dec.cls),
    .funct3  (dec.funct3),
    .zero    (alu_zero),
    .lt      (alu_result[0]),  // SLT and SLTU result bit
    .pc      (pc),
    .imm     (dec.imm),
    .taken   (taken),
    .next_pc (next_pc)
  );

  always_comb
  begin
    out_d              = '0;
    out_d.result       = alu_result;
    out_d.rd           = dec.rd;
    out_d.wr_en        = dec.wr_en;
    out_d.branch_taken = taken;
    out_d.next_pc      = next_pc;
    out_d.illegal      = (dec.cls == cls_illegal);
  end

  // Completion registers
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      done <= 1'b0;
      out  <= '0;
    end
    else
    begin
      done <= issue;
      if (issue)
        out <= out_d;   // Held until next issue
    end
  end

endmodule

// ==== source/branch_unit.sv ====
`timescale 1ns/1ns

module branch_unit (
  input  exec_pkg::instr_class_e    cls,
  input  logic [2:0]                funct3,
  input  logic                      zero,
  input  logic                      lt,
  input  logic [exec_pkg::xlen-1:0] pc,
  input  logic [exec_pkg::xlen-1:0] imm,
  output logic                      taken,
  output logic [exec_pkg::xlen-1:0] next_pc
);

  import exec_pkg::*;

  logic cond;

  always_comb
  begin
    case (funct3)
      f3_beq:  cond = zero;
      f3_bne:  cond = !zero;
      f3_blt:  cond = lt;
      f3_bge:  cond = !lt;
      f3_bltu: cond = lt;      // ALU already did unsigned compare
      f3_bgeu: cond = !lt;
      default: cond = 1'b0;
    endcase
  end

  assign taken = (cls == cls_branch) && cond;

  // Fall-through is the next word
  assign next_pc = taken ? pc + imm : pc + xlen'(4);

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/1ns

module reg_file (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [exec_pkg::reg_aw-1:0] rs1,
  input  logic [exec_pkg::reg_aw-1:0] rs2,
  output logic [exec_pkg::xlen-1:0]   rs1_data,
  output logic [exec_pkg::xlen-1:0]   rs2_data,
  input  logic                        wr,
  input  logic [exec_pkg::reg_aw-1:0] rd,
  input  logic [exec_pkg::xlen-1:0]   wr_data
);

  import exec_pkg::*;

  logic [xlen-1:0] regs [nregs];

  always_ff @(posedge clk)
  begin
    if (rst)
      regs <= '{default: '0};
    else if (wr && rd != '0)
      regs[rd] <= wr_data;  // x0 never written
  end

  // Combinational reads
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== source/alu_decode.sv ====
`timescale 1ns/1ns

module alu_decode (
  input  logic [exec_pkg::xlen-1:0] instr,
  output exec_pkg::dec_t            dec
);

  import exec_pkg::*;

  logic [6:0] funct7;
  logic [2:0] funct3;
  logic       legal;

  assign funct7 = instr[31:25];
  assign funct3 = instr[14:12];

  always_comb
  begin
    dec         = '0;
    dec.op      = alu_add;
    dec.rd      = instr[11:7];
    dec.rs1     = instr[19:15];
    dec.rs2     = instr[24:20];
    dec.funct3  = funct3;
    dec.cls     = cls_illegal;
    legal       = 1'b1;

    case (instr[6:0])
      op_reg:
      begin
        dec.cls   = cls_alu_reg;
        dec.wr_en = 1'b1;
        if (funct7 == f7_base)
        begin
          case (funct3)
            3'b000:  dec.op = alu_add;
            3'b001:  dec.op = alu_sll;
            3'b010:  dec.op = alu_slt;
            3'b011:  dec.op = alu_sltu;
            3'b100:  dec.op = alu_xor;
            3'b101:  dec.op = alu_srl;
            3'b110:  dec.op = alu_or;
            default: dec.op = alu_and;
          endcase
        end
        else if (funct7 == f7_alt && funct3 == 3'b000)
          dec.op = alu_sub;
        else if (funct7 == f7_alt && funct3 == 3'b101)
          dec.op = alu_sra;
        else if (funct7 == f7_mext)
          dec.op = alu_op_e'(5'(alu_mul) + 5'(funct3));  // M group is contiguous
        else
          legal = 1'b0;
      end
      op_imm:
      begin
        dec.cls     = cls_alu_imm;
        dec.wr_en   = 1'b1;
        dec.use_imm = 1'b1;
        dec.imm     = {{(xlen-12){instr[31]}}, instr[31:20]};
        case (funct3)
          3'b000:  dec.op = alu_add;
          3'b010:  dec.op = alu_slt;
          3'b011:  dec.op = alu_sltu;
          3'b100:  dec.op = alu_xor;
          3'b110:  dec.op = alu_or;
          3'b111:  dec.op = alu_and;
          3'b001:
          begin
            dec.op = alu_sll;
            legal  = (funct7 == f7_base);
          end
          default:
          begin
            // SRLI or SRAI by funct7
            dec.op = (funct7 == f7_alt) ? alu_sra : alu_srl;
            legal  = (funct7 == f7_base) || (funct7 == f7_alt);
          end
        endcase
      end
      op_branch:
      begin
        dec.cls = cls_branch;
        dec.imm = {{(xlen-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                   instr[11:8], 1'b0};
        case (funct3)
          f3_beq, f3_bne:   dec.op = alu_sub;   // Decided by zero flag
          f3_blt, f3_bge:   dec.op = alu_slt;
          f3_bltu, f3_bgeu: dec.op = alu_sltu;
          default:          legal  = 1'b0;
        endcase
      end
      default: legal = 1'b0;
    endcase

    if (!legal)
    begin
      dec.cls   = cls_illegal;
      dec.wr_en = 1'b0;
    end
  end

endmodule

// ==== source/alu.sv ====
`timescale 1ns/1ns

module alu (
  input  exec_pkg::alu_op_e         op,
  input  logic [exec_pkg::xlen-1:0] a,
  input  logic [exec_pkg::xlen-1:0] b,
  output logic [exec_pkg::xlen-1:0] result,
  output logic                      zero
);

  import exec_pkg::*;

  logic signed [xlen-1:0] a_s;
  logic signed [xlen-1:0] b_s;
  logic [4:0]             shamt;
  logic [2*xlen-1:0]      prod_ss;
  logic [2*xlen-1:0]      prod_su;
  logic [2*xlen-1:0]      prod_uu;
  logic                   div_zero;
  logic                   div_ovf;

  assign a_s   = a;
  assign b_s   = b;
  assign shamt = b[4:0];  // Only low five bits count

  // Full width products with operands extended per signedness
  assign prod_ss = {{xlen{a[xlen-1]}}, a} * {{xlen{b[xlen-1]}}, b};
  assign prod_su = {{xlen{a[xlen-1]}}, a} * {{xlen{1'b0}}, b};
  assign prod_uu = {{xlen{1'b0}}, a} * {{xlen{1'b0}}, b};

  assign div_zero = (b == '0);
  // Most negative value divided by minus one
  assign div_ovf  = (a == {1'b1, {(xlen-1){1'b0}}}) && (&b);

  always_comb
  begin
    case (op)
      alu_and:    result = a & b;
      alu_or:     result = a | b;
      alu_add:    result = a + b;
      alu_xor:    result = a ^ b;
      alu_sub:    result = a - b;
      alu_not:    result = ~a;
      alu_sll:    result = a << shamt;
      alu_srl:    result = a >> shamt;
      alu_sra:    result = a_s >>> shamt;
      alu_slt:    result = {{(xlen-1){1'b0}}, (a_s < b_s)};
      alu_sltu:   result = {{(xlen-1){1'b0}}, (a < b)};
      alu_mul:    result = prod_uu[xlen-1:0];    // Low half same for all signs
      alu_mulh:   result = prod_ss[2*xlen-1:xlen];
      alu_mulhsu: result = prod_su[2*xlen-1:xlen];
      alu_mulhu:  result = prod_uu[2*xlen-1:xlen];
      alu_div:
      begin
        if (div_zero)
          result = '1;
        else if (div_ovf)
          result = a;                            // Quotient wraps to dividend
        else
          result = a_s / b_s;
      end
      alu_divu:   result = div_zero ? '1 : a / b;
      alu_rem:
      begin
        if (div_zero)
          result = a;
        else if (div_ovf)
          result = '0;
        else
          result = a_s % b_s;                    // Sign follows dividend
      end
      alu_remu:   result = div_zero ? a : a % b;
      default:    result = '0;
    endcase
  end

  assign zero = (result == '0);

endmodule

// ==== source/exec_pkg.sv ====
package exec_pkg;

  localparam int unsigned xlen   = 32;
  localparam int unsigned reg_aw = 5;             // Register index width
  localparam int unsigned nregs  = 1 << reg_aw;

  // ALU operation codes
  typedef enum logic [4:0] {
    alu_and    = 5'b00000,
    alu_or     = 5'b00001,
    alu_add    = 5'b00010,
    alu_xor    = 5'b00011,
    alu_sub    = 5'b00100,
    alu_not    = 5'b00101,
    alu_sll    = 5'b00110,
    alu_srl    = 5'b00111,
    alu_sra    = 5'b01000,
    alu_slt    = 5'b01001,
    alu_sltu   = 5'b01010,
    alu_mul    = 5'b01011,
    alu_mulh   = 5'b01100,
    alu_mulhsu = 5'b01101,
    alu_mulhu  = 5'b01110,
    alu_div    = 5'b01111,
    alu_divu   = 5'b10000,
    alu_rem    = 5'b10001,
    alu_remu   = 5'b10010
  } alu_op_e;

  // Major opcodes handled by the core
  typedef enum logic [6:0] {
    op_reg    = 7'b0110011,
    op_imm    = 7'b0010011,
    op_branch = 7'b1100011
  } opcode_e;

  typedef enum logic [1:0] {
    cls_alu_reg,
    cls_alu_imm,
    cls_branch,
    cls_illegal
  } instr_class_e;

  // Branch conditions
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000;  // SUB and SRA
  localparam logic [6:0] f7_mext = 7'b0000001;  // Multiply and divide group

  typedef struct packed {
    alu_op_e             op;
    instr_class_e        cls;
    logic [reg_aw-1:0]   rs1;
    logic [reg_aw-1:0]   rs2;
    logic [reg_aw-1:0]   rd;
    logic [xlen-1:0]     imm;
    logic                use_imm;
    logic [2:0]          funct3;
    logic                wr_en;
  } dec_t;

  typedef struct packed {
    logic [xlen-1:0]     result;
    logic [reg_aw-1:0]   rd;
    logic                wr_en;
    logic                branch_taken;
    logic [xlen-1:0]     next_pc;
    logic                illegal;
  } exec_out_t;

endpackage
